// ==== test/branch_vectors.txt ====
// Columns, hex: op pc immediate index reg_a reg_b, then expected
// taken target link_wr link_addr fetch_disable.
// "group <gaps> <name>" opens a group, gaps 1 adds 0 to 2 idle cycles per vector.
group 1 conditional
3 010 00000005 0000000 00000007 00000007 1 015 0 011 0
3 020 fffffffc 0000000 00000001 00000002 0 01c 0 021 0
3 400 00012345 0000000 00000005 00000005 1 745 0 401 0
4 100 00000010 0000000 12345678 12345679 1 110 0 101 0
4 7fe 00000004 0000000 aaaa5555 aaaa5555 0 002 0 7ff 0
4 500 00000400 0000000 00000001 00000000 1 100 0 501 0
5 050 0000000a 0000000 ffffffff 00000000 1 05a 0 051 0
5 060 00000003 0000000 00000000 00000000 1 063 0 061 0
5 070 fffffff0 0000000 00000001 00000000 0 060 0 071 0
5 7ff 00000001 0000000 80000000 00000000 1 000 0 000 0
6 003 fffffff8 0000000 7fffffff 00000000 1 7fb 0 004 0
6 200 00000001 0000000 00000000 00000000 0 201 0 201 0
6 300 0000000f 0000000 80000000 00000000 0 30f 0 301 0
// Register jumps ignore the immediate.
group 1 register_jumps
1 123 00000010 0000000 00000456 00000000 1 456 0 124 0
1 7ff 00000000 0000000 fffff8ab 00000000 1 0ab 0 000 0
2 040 00000000 0000000 00000777 00000000 1 777 1 041 0
2 7ff 00000000 0000000 12345fff 00000000 1 7ff 1 000 0
// Index jumps keep only the low 11 index bits.
group 1 index_jumps
7 010 00000000 0000123 00000000 00000000 1 123 0 011 1
7 222 00000005 3ffffff 00000000 00000000 1 7ff 0 223 1
8 333 00000000 2abcdef 00000000 00000000 1 5ef 1 334 1
8 7ff 00000000 0000001 00000000 00000000 1 001 1 000 1
group 1 no_branch
0 100 00000020 0000000 00000001 00000001 0 120 0 101 0
0 7f0 00000020 0000000 00000000 00000000 0 010 0 7f1 0
// Back to back, no idle cycles.
group 0 throughput
3 000 00000002 0000000 00000003 00000003 1 002 0 001 0
4 001 00000002 0000000 00000003 00000003 0 003 0 002 0
1 002 00000000 0000000 00000100 00000000 1 100 0 003 0
8 003 00000000 0000040 00000000 00000000 1 040 1 004 1
6 004 ffffffff 0000000 00000009 00000000 1 003 0 005 0
0 005 00000000 0000000 00000000 00000000 0 005 0 006 0
5 006 00000001 0000000 00000005 00000000 0 007 0 007 0

// ==== tb.f ====
common/branch_pkg.sv
common/branch_if.sv
hw/branch_target/branch_target_calc.sv
hw/branch_condition/branch_condition_eval.sv
hw/branch_resolver.sv
hw/branch_unit.sv
test/tb_branch_unit.sv

// ==== Makefile ====
TOOL      ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_branch_unit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir

SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a listed source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_branch_unit;

   localparam int    ADDR_W   = 11;
   localparam int    DATA_W   = 32;
   localparam int    INDEX_W  = 26;
   localparam int    MAX_VEC  = 64;
   localparam int    MAX_GRP  = 8;
   localparam string VEC_FILE = "test/branch_vectors.txt";

   logic                i_clk;
   logic                i_rst_n;
   logic                i_valid;
   logic [3:0]          i_branch_op;
   logic [ADDR_W-1:0]   i_pc;
   logic [DATA_W-1:0]   i_immediate;
   logic [INDEX_W-1:0]  i_instr_index;
   logic [DATA_W-1:0]   i_reg_a;
   logic [DATA_W-1:0]   i_reg_b;
   logic                o_valid;
   logic                o_taken;
   logic [ADDR_W-1:0]   o_target;
   logic                o_link_wr;
   logic [ADDR_W-1:0]   o_link_addr;
   logic                o_fetch_disable;

   // One entry per vector line.
   logic [31:0] vec_op     [MAX_VEC];
   logic [31:0] vec_pc     [MAX_VEC];
   logic [31:0] vec_imm    [MAX_VEC];
   logic [31:0] vec_index  [MAX_VEC];
   logic [31:0] vec_a      [MAX_VEC];
   logic [31:0] vec_b      [MAX_VEC];
   logic [31:0] exp_taken  [MAX_VEC];
   logic [31:0] exp_target [MAX_VEC];
   logic [31:0] exp_lwr    [MAX_VEC];
   logic [31:0] exp_laddr  [MAX_VEC];
   logic [31:0] exp_fdis   [MAX_VEC];
   int          vec_group  [MAX_VEC];
   string       group_name [MAX_GRP];
   int          group_gaps [MAX_GRP];  // Nonzero adds random idle cycles.
   int          group_last [MAX_GRP];

   int          nvec        = 0;
   int          ngroups     = 0;
   int          npass       = 0;
   int          nfail       = 0;
   int          fail_base   = 0;
   int          cycles      = 0;
   int          cycle_limit = 1000;
   int          seed_init;
   int          gap;
   int          vi;
   int          idx_q [$];  // Vectors in flight in issue order.
   logic [1:0]  valid_hist  = 2'b00;
   logic        exp_valid;
   logic [31:0] last_target = '0;  // Target the redirect must hold while idle.

   branch_unit u_branch_unit (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_valid         (i_valid),
      .i_branch_op     (i_branch_op),
      .i_pc            (i_pc),
      .i_immediate     (i_immediate),
      .i_instr_index   (i_instr_index),
      .i_reg_a         (i_reg_a),
      .i_reg_b         (i_reg_b),
      .o_valid         (o_valid),
      .o_taken         (o_taken),
      .o_target        (o_target),
      .o_link_wr       (o_link_wr),
      .o_link_addr     (o_link_addr),
      .o_fetch_disable (o_fetch_disable)
   );

   always #2 i_clk = ~i_clk;  // 4 ns period.

   //////////////////////////////////////////////////////////////////////
   // Helpers.
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         nfail++;
         $display("Error: %s expected 0x%h got 0x%h", name, exp, act);
      end else begin
         npass++;
      end
   endtask

   task automatic report_test(input string name);
      $display("Test %-15s done, %0d errors", name, nfail - fail_base);
      fail_base = nfail;
   endtask

   task automatic read_vectors();
      int    fd;
      int    n;
      int    gaps;
      string line;
      string word;
      string gname;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("Vector file %s could not be opened", VEC_FILE);
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         word = "";
         n = $fgets(line, fd);
         n = $sscanf(line, "%s", word);
         if (n >= 1 && word.len() > 0 && word[0] != "/") begin  // Skip comments.
            if (word == "group" && ngroups < MAX_GRP) begin
               n = $sscanf(line, "%s %d %s", word, gaps, gname);
               group_name[ngroups] = gname;
               group_gaps[ngroups] = gaps;
               ngroups++;
            end else if (nvec < MAX_VEC && ngroups > 0) begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                           vec_op[nvec], vec_pc[nvec], vec_imm[nvec], vec_index[nvec],
                           vec_a[nvec], vec_b[nvec], exp_taken[nvec], exp_target[nvec],
                           exp_lwr[nvec], exp_laddr[nvec], exp_fdis[nvec]);
               if (n == 11) begin
                  vec_group[nvec]         = ngroups - 1;
                  group_last[ngroups - 1] = nvec;
                  nvec++;
               end else begin
                  nfail++;
                  $display("A vector line has %0d fields instead of 11", n);
               end
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic drive_vector(input int i);
      @(posedge i_clk);
      #1;
      i_valid       = 1'b1;
      i_branch_op   = vec_op[i][3:0];
      i_pc          = vec_pc[i][ADDR_W-1:0];
      i_immediate   = vec_imm[i];
      i_instr_index = vec_index[i][INDEX_W-1:0];
      i_reg_a       = vec_a[i];
      i_reg_b       = vec_b[i];
      idx_q.push_back(i);
   endtask

   task automatic idle_cycle();
      @(posedge i_clk);
      #1;
      i_valid = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Output monitor. Samples mid-cycle.
   //////////////////////////////////////////////////////////////////////

   always @(negedge i_clk) begin
      if (cycles >= 1) begin
         exp_valid = valid_hist[1];  // i_valid two cycles back.
         check_value("o_valid", 32'(exp_valid), 32'(o_valid));
         if (exp_valid) begin
            vi = idx_q.pop_front();
            check_value("o_taken", exp_taken[vi], 32'(o_taken));
            check_value("o_target", exp_target[vi], 32'(o_target));
            check_value("o_link_wr", exp_lwr[vi], 32'(o_link_wr));
            check_value("o_link_addr", exp_laddr[vi], 32'(o_link_addr));
            check_value("o_fetch_disable", exp_fdis[vi], 32'(o_fetch_disable));
            last_target = exp_target[vi];
            if (vi == group_last[vec_group[vi]]) begin
               report_test(group_name[vec_group[vi]]);
            end
         end else begin
            check_value("o_taken", 32'd0, 32'(o_taken));  // Idle cycle keeps controls low.
            check_value("o_link_wr", 32'd0, 32'(o_link_wr));
            check_value("o_fetch_disable", 32'd0, 32'(o_fetch_disable));
            check_value("o_target", last_target, 32'(o_target));
         end
      end
      valid_hist = {valid_hist[0], i_valid};
   end

   always @(posedge i_clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Run timed out after %0d cycles before all results arrived", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus.
   //////////////////////////////////////////////////////////////////////

   initial begin
      seed_init     = $urandom(25583);
      i_clk         = 1'b0;
      i_rst_n       = 1'b0;
      i_valid       = 1'b0;
      i_branch_op   = '0;
      i_pc          = '0;
      i_immediate   = '0;
      i_instr_index = '0;
      i_reg_a       = '0;
      i_reg_b       = '0;
      read_vectors();
      cycle_limit = 4 * nvec + 50;
      if (nvec == 0) begin
         nfail++;
         $display("No vectors were read, nothing to run");
      end else begin
         repeat (5) @(posedge i_clk);
         #1 i_rst_n = 1'b1;
         repeat (2) idle_cycle();
         @(negedge i_clk);
         check_value("o_target", 32'd0, 32'(o_target));  // Reset value.
         check_value("o_link_addr", 32'd0, 32'(o_link_addr));
         report_test("reset");
         for (int i = 0; i < nvec; i++) begin
            if (group_gaps[vec_group[i]] != 0) begin
               gap = $urandom % 3;
               repeat (gap) idle_cycle();
            end
            drive_vector(i);
         end
         idle_cycle();
         while (idx_q.size() != 0) @(negedge i_clk);
         repeat (3) @(posedge i_clk);
         #1;
      end
      $display("Summary: %0d checks passed, %0d checks failed", npass, nfail);
      if (nfail == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_unit #(
   parameter int ADDR_W  = 11,
   parameter int DATA_W  = 32,
   parameter int INDEX_W = 26
) (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_valid,
   input  wire  [branch_pkg::BR_OP_W-1:0] i_branch_op,
   input  wire  [ADDR_W-1:0]             i_pc,
   input  wire  [DATA_W-1:0]             i_immediate,
   input  wire  [INDEX_W-1:0]            i_instr_index,
   input  wire  [DATA_W-1:0]             i_reg_a,
   input  wire  [DATA_W-1:0]             i_reg_b,
   output logic                          o_valid,
   output logic                          o_taken,
   output logic [ADDR_W-1:0]             o_target,
   output logic                          o_link_wr,
   output logic [ADDR_W-1:0]             o_link_addr,
   output logic                          o_fetch_disable
);

   branch_pkg::branch_op_e branch_op;

   assign branch_op = branch_pkg::branch_op_e'(i_branch_op);  // Raw code to enum.

   target_if #(.ADDR_W(ADDR_W)) tgt_bus ();
   cond_if                      cond_bus ();

   //////////////////////////////////////////////////////////////////////
   // Target and condition, side by side on the same operands.
   //////////////////////////////////////////////////////////////////////

   branch_target_calc #(
      .ADDR_W  (ADDR_W),
      .DATA_W  (DATA_W),
      .INDEX_W (INDEX_W)
   ) u_branch_target_calc (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_valid       (i_valid),
      .i_branch_op   (branch_op),
      .i_pc          (i_pc),
      .i_immediate   (i_immediate),
      .i_instr_index (i_instr_index),
      .i_reg_a       (i_reg_a),
      .o_tgt         (tgt_bus)
   );

   branch_condition_eval #(
      .DATA_W (DATA_W)
   ) u_branch_condition_eval (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (i_valid),
      .i_branch_op (branch_op),
      .i_reg_a     (i_reg_a),
      .i_reg_b     (i_reg_b),
      .o_cond      (cond_bus)
   );

   // Fetch redirect, two cycles after i_valid.
   branch_resolver #(
      .ADDR_W (ADDR_W)
   ) u_branch_resolver (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_tgt           (tgt_bus),
      .i_cond          (cond_bus),
      .o_valid         (o_valid),
      .o_taken         (o_taken),
      .o_target        (o_target),
      .o_link_wr       (o_link_wr),
      .o_link_addr     (o_link_addr),
      .o_fetch_disable (o_fetch_disable)
   );

endmodule

`default_nettype wire

// ==== hw/branch_resolver.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_resolver #(
   parameter int ADDR_W = 11
) (
   input  wire                 i_clk,
   input  wire                 i_rst_n,
   target_if.sink              i_tgt,
   cond_if.sink                i_cond,
   output logic                o_valid,
   output logic                o_taken,
   output logic [ADDR_W-1:0]   o_target,
   output logic                o_link_wr,
   output logic [ADDR_W-1:0]   o_link_addr,
   output logic                o_fetch_disable
);

   logic any_valid;
   logic both_valid;
   logic taken;

   //////////////////////////////////////////////////////////////////////
   // Taken decision.
   //////////////////////////////////////////////////////////////////////

   assign any_valid  = i_tgt.valid || i_cond.valid;
   assign both_valid = i_tgt.valid && i_cond.valid;

   // Producers out of step never redirect.
   assign taken = both_valid &&
                  (i_tgt.unconditional || (i_cond.op_is_cond && i_cond.cond_true));

   //////////////////////////////////////////////////////////////////////
   // Redirect register.
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_valid         <= 1'b0;
         o_taken         <= 1'b0;
         o_link_wr       <= 1'b0;
         o_fetch_disable <= 1'b0;
      end else begin
         o_valid         <= any_valid;
         o_taken         <= taken;
         o_link_wr       <= i_tgt.valid && i_tgt.link_wr;      // Zero when idle.
         o_fetch_disable <= i_tgt.valid && i_tgt.fetch_disable;
      end
   end

   // Addresses hold their last resolved value between operations.
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_target    <= '0;
         o_link_addr <= '0;
      end else if (i_tgt.valid) begin
         o_target    <= i_tgt.target;
         o_link_addr <= i_tgt.link_addr;
      end
   end

endmodule

`default_nettype wire

// ==== hw/branch_condition/branch_condition_eval.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_condition_eval #(
   parameter int DATA_W = 32
) (
   input  wire                        i_clk,
   input  wire                        i_rst_n,
   input  wire                        i_valid,
   input  branch_pkg::branch_op_e     i_branch_op,
   input  wire  [DATA_W-1:0]          i_reg_a,
   input  wire  [DATA_W-1:0]          i_reg_b,
   cond_if.source                     o_cond
);

   logic a_eq_b;
   logic a_neg;
   logic a_zero;
   logic next_cond;
   logic next_is_cond;

   //////////////////////////////////////////////////////////////////////
   // Operand tests.
   //////////////////////////////////////////////////////////////////////

   assign a_eq_b = (i_reg_a == i_reg_b);
   assign a_neg  = i_reg_a[DATA_W-1];     // Sign bit of A.
   assign a_zero = (i_reg_a == '0);

   // Condition by opcode, zero for anything unconditional.
   always_comb begin
      next_cond    = 1'b0;
      next_is_cond = 1'b1;
      case (i_branch_op)
         branch_pkg::BR_BEQ:  next_cond = a_eq_b;
         branch_pkg::BR_BNE:  next_cond = !a_eq_b;
         branch_pkg::BR_BLEZ: next_cond = a_neg || a_zero;    // A <= 0.
         branch_pkg::BR_BGTZ: next_cond = !a_neg && !a_zero;  // A > 0.
         default: begin
            next_is_cond = 1'b0;  // Jumps and none.
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Output register.
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_cond.valid      <= 1'b0;
         o_cond.cond_true  <= 1'b0;
         o_cond.op_is_cond <= 1'b0;
      end else begin
         o_cond.valid <= i_valid;
         if (i_valid) begin
            o_cond.cond_true  <= next_cond;
            o_cond.op_is_cond <= next_is_cond;
         end
      end
   end

   // Debug only.
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         o_cond.equal <= a_eq_b;
      end
   end

endmodule

`default_nettype wire

// ==== hw/branch_target/branch_target_calc.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_target_calc #(
   parameter int ADDR_W  = 11,
   parameter int DATA_W  = 32,
   parameter int INDEX_W = 26
) (
   input  wire                        i_clk,
   input  wire                        i_rst_n,
   input  wire                        i_valid,
   input  branch_pkg::branch_op_e     i_branch_op,
   input  wire  [ADDR_W-1:0]          i_pc,
   input  wire  [DATA_W-1:0]          i_immediate,
   input  wire  [INDEX_W-1:0]         i_instr_index,
   input  wire  [DATA_W-1:0]          i_reg_a,
   target_if.source                   o_tgt
);

   logic [ADDR_W-1:0] pc_rel_target;
   logic [ADDR_W-1:0] next_target;
   logic [ADDR_W-1:0] next_link_addr;
   logic              next_uncond;
   logic              next_link_wr;
   logic              next_fetch_dis;

   //////////////////////////////////////////////////////////////////////
   // Address arithmetic.
   //////////////////////////////////////////////////////////////////////

   // PC counts instructions, so the immediate goes in unshifted.
   // Signed add, wraps modulo 2^ADDR_W.
   assign pc_rel_target  = ADDR_W'($signed(i_pc) + $signed(i_immediate[ADDR_W-1:0]));
   assign next_link_addr = i_pc + ADDR_W'(1);  // Return address.

   //////////////////////////////////////////////////////////////////////
   // Opcode decode and target select.
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      next_target    = pc_rel_target;  // Default for conditional and none.
      next_uncond    = 1'b0;
      next_link_wr   = 1'b0;
      next_fetch_dis = 1'b0;
      case (i_branch_op)
         branch_pkg::BR_JR: begin
            next_target = i_reg_a[ADDR_W-1:0];
            next_uncond = 1'b1;
         end
         branch_pkg::BR_JALR: begin
            next_target  = i_reg_a[ADDR_W-1:0];
            next_uncond  = 1'b1;
            next_link_wr = 1'b1;
         end
         branch_pkg::BR_J,
         branch_pkg::BR_JAL: begin
            // Index truncated, no upper PC bits joined on.
            next_target    = i_instr_index[ADDR_W-1:0];
            next_uncond    = 1'b1;
            next_fetch_dis = 1'b1;
            next_link_wr   = (i_branch_op == branch_pkg::BR_JAL);
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Output register.
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_tgt.valid         <= 1'b0;
         o_tgt.unconditional <= 1'b0;
         o_tgt.link_wr       <= 1'b0;
         o_tgt.fetch_disable <= 1'b0;
      end else begin
         o_tgt.valid <= i_valid;  // One-cycle strobe.
         if (i_valid) begin
            o_tgt.unconditional <= next_uncond;
            o_tgt.link_wr       <= next_link_wr;
            o_tgt.fetch_disable <= next_fetch_dis;
         end
      end
   end

   // Address payload, no reset.
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         o_tgt.target    <= next_target;
         o_tgt.link_addr <= next_link_addr;
      end
   end

endmodule

`default_nettype wire

// ==== common/branch_if.sv ====
`timescale 1ns/1ns
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Target path. Target calculator to resolver.
//////////////////////////////////////////////////////////////////////

interface target_if #(
   parameter int ADDR_W = 11
);

   logic              valid;          // One-cycle strobe.
   logic [ADDR_W-1:0] target;         // Redirect address.
   logic              unconditional;  // JR, JALR, J, JAL.
   logic              link_wr;        // JALR, JAL.
   logic [ADDR_W-1:0] link_addr;      // PC plus one.
   logic              fetch_disable;  // J, JAL.

   modport source (
      output valid, target, unconditional, link_wr, link_addr, fetch_disable
   );

   modport sink (
      input valid, target, unconditional, link_wr, link_addr, fetch_disable
   );

endinterface

//////////////////////////////////////////////////////////////////////
// Condition path. Condition evaluator to resolver.
//////////////////////////////////////////////////////////////////////

// Carries no address, so no width parameter.
interface cond_if;

   logic valid;       // One-cycle strobe.
   logic cond_true;   // Condition holds, zero for non-conditional ops.
   logic op_is_cond;  // BEQ, BNE, BLEZ, BGTZ.
   logic equal;       // A == B, debug view only.

   modport source (
      output valid, cond_true, op_is_cond, equal
   );

   // Equal is not exported to the resolver.
   modport sink (
      input valid, cond_true, op_is_cond
   );

endinterface

`default_nettype wire

// ==== common/branch_pkg.sv ====
`default_nettype none

package branch_pkg;

   //////////////////////////////////////////////////////////////////////
   // Branch opcode.
   //////////////////////////////////////////////////////////////////////

   localparam int BR_OP_W = 4;  // Width of the decoded opcode.

   // Decoded branch operation, as presented by the decoder.
   // Numeric codes 0 to 8 are also used by the vector file.
   typedef enum logic [BR_OP_W-1:0] {
      BR_NONE = 4'd0,  // No branch this cycle.
      BR_JR   = 4'd1,  // Jump to register A.
      BR_JALR = 4'd2,  // Jump to register A and link.
      BR_BEQ  = 4'd3,  // Branch if A == B.
      BR_BNE  = 4'd4,  // Branch if A != B.
      BR_BLEZ = 4'd5,  // Branch if signed A <= 0.
      BR_BGTZ = 4'd6,  // Branch if signed A > 0.
      BR_J    = 4'd7,  // Jump to instruction index.
      BR_JAL  = 4'd8   // Jump to instruction index and link.
   } branch_op_e;

   // Codes 9 to 15 are unused and
   // decode like BR_NONE in every block.

endpackage

`default_nettype wire
